// ==== logic/basic_ptr_init.sv ====
// Writes only the BASIC pointers in page zero; the PRG is assumed to be loaded for BASIC at $0801
`timescale 1ns/1ps

module basic_ptr_init #(
	parameter int ADDR_W = 25
) (
	input  logic                clk_sys,
	input  logic                reset_n,
	input  logic                prg_done_i,
	input  loader_pkg::word16_t prg_end_i,
	input  logic                busy_i,
	output logic                init_req_o,
	output logic [ADDR_W-1:0]   init_addr_o,
	output loader_pkg::byte_t   init_data_o
);
	import loader_pkg::*;

	localparam logic [8:0] ZP_END = 9'h100;  // One past the last zero-page byte

	logic       active;
	logic [8:0] zp_addr;
	word16_t    end_addr;
	logic       ptr_hit;
	byte_t      ptr_data;

	// ==============================
	// Pointer table
	// ==============================

	always_comb begin
		ptr_hit  = 1'b1;
		ptr_data = 8'h00;
		case (zp_addr[7:0])
			// Program start as after power-up
			8'h2B: ptr_data = 8'h01;
			8'h2C: ptr_data = 8'h08;
			8'hAC, 8'hAD: ptr_data = 8'h00;  // SAVE start
			// Variables, arrays, strings and load end all sit past the program
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_data = end_addr[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_data = end_addr[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	// ==============================
	// Zero-page walk
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active     <= 1'b0;
			zp_addr    <= '0;
			init_req_o <= 1'b0;
		end else begin
			init_req_o <= 1'b0;
			if (prg_done_i) begin
				active   <= 1'b1;
				zp_addr  <= '0;
				end_addr <= prg_end_i;
			end else if (active) begin
				if (zp_addr == ZP_END) begin
					active <= 1'b0;
				end else if (!ptr_hit) begin
					zp_addr <= zp_addr + 1'b1;  // Nothing to store here
				end else if (!busy_i && !init_req_o) begin
					// Writer flags busy one cycle after our strobe, so skip that cycle too
					init_req_o  <= 1'b1;
					init_addr_o <= ADDR_W'(zp_addr[7:0]);
					init_data_o <= ptr_data;
					zp_addr     <= zp_addr + 1'b1;
				end
			end
		end
	end

endmodule

// ==== logic/download_parser.sv ====
// Handles PRG, CRT and TAP only; ioctl_index_i must stay stable while the download level is high
`timescale 1ns/1ps

module download_parser #(
	parameter int                ADDR_W    = 25,
	parameter logic [ADDR_W-1:0] CART_BASE = 'h100000,
	parameter logic [ADDR_W-1:0] TAP_BASE  = 'h200000
) (
	input  logic                clk_sys,
	input  logic                reset_n,
	input  logic                ioctl_download_i,
	input  logic [7:0]          ioctl_index_i,
	input  logic [ADDR_W-1:0]   ioctl_addr_i,
	input  loader_pkg::byte_t   ioctl_data_i,
	input  logic                ioctl_wr_i,
	output logic                req_wr_o,
	output logic [ADDR_W-1:0]   req_addr_o,
	output loader_pkg::byte_t   req_data_o,
	output logic                prg_done_o,
	output loader_pkg::word16_t prg_end_o,
	output loader_pkg::word16_t cart_id_o,
	output loader_pkg::byte_t   cart_exrom_o,
	output loader_pkg::byte_t   cart_game_o,
	output loader_pkg::byte_t   cart_bank_type_o,
	output loader_pkg::word16_t cart_bank_num_o,
	output loader_pkg::word16_t cart_bank_laddr_o,
	output loader_pkg::word16_t cart_bank_size_o,
	output logic                cart_bank_wr_o,
	output logic                cart_attached_o
);
	import loader_pkg::*;

	localparam int ALIGN_W = 13;  // 8 KB chip alignment

	logic              load_prg;
	logic              load_cart;
	logic              load_tap;
	logic              host_wr;
	logic              old_download;
	logic              dl_rise;
	logic              dl_fall;
	logic              chip_area;
	logic [ADDR_W-1:0] load_addr;  // Next memory address to write
	logic [ADDR_W-1:0] tap_addr;
	logic [3:0]        hdr_cnt;    // Position inside a CHIP header, 0 when idle
	logic [31:0]       blk_len;    // Data bytes left in the current CHIP packet

	// ==============================
	// Download decode
	// ==============================

	assign load_prg  = (ioctl_index_i[7:6] == 2'b00) && (ioctl_index_i[5:0] == IDX_PRG[5:0]);
	assign load_cart = (ioctl_index_i == IDX_CRT) || (ioctl_index_i == IDX_CRT_ALT);
	assign load_tap  = (ioctl_index_i == IDX_TAP);

	assign host_wr   = ioctl_wr_i & ioctl_download_i;
	assign dl_rise   = ~old_download & ioctl_download_i;
	assign dl_fall   = old_download & ~ioctl_download_i;
	assign chip_area = (ioctl_addr_i >= ADDR_W'(CRT_CHIP_START));

	// Tape data starts at its base on the very first byte
	assign tap_addr  = (ioctl_addr_i == '0) ? TAP_BASE : load_addr;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			old_download    <= 1'b0;
			req_wr_o        <= 1'b0;
			prg_done_o      <= 1'b0;
			cart_bank_wr_o  <= 1'b0;
			cart_attached_o <= 1'b0;
			hdr_cnt         <= '0;
			blk_len         <= '0;
		end else begin
			old_download   <= ioctl_download_i;
			req_wr_o       <= 1'b0;
			cart_bank_wr_o <= 1'b0;
			prg_done_o     <= dl_fall & load_prg;  // Kicks off the zero-page walk

			// PRG: two-byte little-endian load address, then payload
			if (host_wr && load_prg) begin
				if (ioctl_addr_i == '0) begin
					load_addr <= ADDR_W'(ioctl_data_i);
					prg_end_o <= {8'h00, ioctl_data_i};
				end else if (ioctl_addr_i == ADDR_W'(1)) begin
					load_addr <= ADDR_W'({ioctl_data_i, load_addr[7:0]});
					prg_end_o <= {ioctl_data_i, prg_end_o[7:0]};
				end else begin
					req_wr_o   <= 1'b1;
					req_addr_o <= load_addr;
					req_data_o <= ioctl_data_i;
					load_addr  <= load_addr + 1'b1;
					prg_end_o  <= prg_end_o + 1'b1;
				end
			end

			// CRT: fixed header fields, then a chain of CHIP packets
			if (host_wr && load_cart) begin
				if (ioctl_addr_i == ADDR_W'(CRT_HDR_ID))       cart_id_o[15:8] <= ioctl_data_i;
				if (ioctl_addr_i == ADDR_W'(CRT_HDR_ID) + 1'b1) cart_id_o[7:0]  <= ioctl_data_i;
				if (ioctl_addr_i == ADDR_W'(CRT_HDR_EXROM))    cart_exrom_o    <= ioctl_data_i;
				if (ioctl_addr_i == ADDR_W'(CRT_HDR_GAME))     cart_game_o     <= ioctl_data_i;

				if (ioctl_addr_i == '0) begin
					load_addr <= CART_BASE;
					blk_len   <= '0;
					hdr_cnt   <= '0;
				end else if (chip_area) begin
					if (blk_len == '0 && hdr_cnt == '0) begin
						hdr_cnt <= 4'd1;  // New packet header
						if (load_addr[ALIGN_W-1:0] != '0) begin
							load_addr <= {load_addr[ADDR_W-1:ALIGN_W] + 1'b1, {ALIGN_W{1'b0}}};
						end
					end else if (hdr_cnt != '0) begin
						hdr_cnt <= hdr_cnt + 1'b1;  // Wraps to 0 after byte 15
						case (hdr_cnt)
							4'd4:  blk_len[31:24] <= ioctl_data_i;
							4'd5:  blk_len[23:16] <= ioctl_data_i;
							4'd6:  blk_len[15:8]  <= ioctl_data_i;
							4'd7:  blk_len[7:0]   <= ioctl_data_i;
							4'd8:  blk_len <= blk_len - 32'd16;  // Length counts the header too
							4'd9:  cart_bank_type_o        <= ioctl_data_i;
							4'd10: cart_bank_num_o[15:8]   <= ioctl_data_i;
							4'd11: cart_bank_num_o[7:0]    <= ioctl_data_i;
							4'd12: cart_bank_laddr_o[15:8] <= ioctl_data_i;
							4'd13: cart_bank_laddr_o[7:0]  <= ioctl_data_i;
							4'd14: cart_bank_size_o[15:8]  <= ioctl_data_i;
							4'd15: begin
								cart_bank_size_o[7:0] <= ioctl_data_i;
								cart_bank_wr_o        <= 1'b1;
							end
							default: ;
						endcase
					end else begin
						blk_len    <= blk_len - 1'b1;
						req_wr_o   <= 1'b1;
						req_addr_o <= load_addr;
						req_data_o <= ioctl_data_i;
						load_addr  <= load_addr + 1'b1;
					end
				end
			end

			// TAP: every byte is stored
			if (host_wr && load_tap) begin
				req_wr_o   <= 1'b1;
				req_addr_o <= tap_addr;
				req_data_o <= ioctl_data_i;
				load_addr  <= tap_addr + 1'b1;
			end

			// A new cartridge detaches the old one until it is complete
			if (load_cart && dl_rise) begin
				cart_attached_o <= 1'b0;
			end else if (load_cart && dl_fall) begin
				cart_attached_o <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/loader_pkg.sv ====
// Index codes follow the host download menu; CRT offsets assume a version 1 cartridge header
package loader_pkg;

	// ==============================
	// Data types
	// ==============================

	typedef logic [7:0]  byte_t;    // Download and memory data
	typedef logic [15:0] word16_t;  // Big-endian header fields, PRG addresses

	// ==============================
	// Host download indices
	// ==============================

	// PRG is matched on the low six bits with the top two clear
	localparam byte_t IDX_PRG     = 8'h04;

	// Two menu entries load cartridges
	localparam byte_t IDX_CRT     = 8'h05;
	localparam byte_t IDX_CRT_ALT = 8'hC0;

	localparam byte_t IDX_TAP     = 8'h06;  // Raw tape image

	// ==============================
	// CRT file layout
	// ==============================

	// Hardware type, two bytes, high byte first
	localparam byte_t CRT_HDR_ID     = 8'h16;

	// Line levels the cartridge wants at power-up
	localparam byte_t CRT_HDR_EXROM  = 8'h18;
	localparam byte_t CRT_HDR_GAME   = 8'h19;

	// First CHIP packet follows the fixed header
	localparam byte_t CRT_CHIP_START = 8'h40;

	// CHIP packet layout relative to its first byte
	//   0..3   signature
	//   4..7   packet length including header
	//   8..9   chip type
	//   10..11 bank number
	//   12..13 load address
	//   14..15 image size

endpackage

// ==== logic/loader_top.sv ====
// File loading path only; the core must provide io_cycle_i and own memory outside the write strobe
`timescale 1ns/1ps

module loader_top #(
	parameter int                ADDR_W    = 25,
	parameter logic [ADDR_W-1:0] CART_BASE = 'h100000,
	parameter logic [ADDR_W-1:0] TAP_BASE  = 'h200000
) (
	input  logic                clk_sys,
	input  logic                reset_n,
	// Host download port
	input  logic                ioctl_download_i,
	input  logic [7:0]          ioctl_index_i,
	input  logic [ADDR_W-1:0]   ioctl_addr_i,
	input  loader_pkg::byte_t   ioctl_data_i,
	input  logic                ioctl_wr_i,
	output logic                ioctl_wait_o,
	// Memory port
	input  logic                io_cycle_i,
	output logic                mem_ce_o,
	output logic                mem_we_o,
	output logic [ADDR_W-1:0]   mem_addr_o,
	output loader_pkg::byte_t   mem_data_o,
	// Cartridge description
	output loader_pkg::word16_t cart_id_o,
	output loader_pkg::byte_t   cart_exrom_o,
	output loader_pkg::byte_t   cart_game_o,
	output loader_pkg::byte_t   cart_bank_type_o,
	output loader_pkg::word16_t cart_bank_num_o,
	output loader_pkg::word16_t cart_bank_laddr_o,
	output loader_pkg::word16_t cart_bank_size_o,
	output logic                cart_bank_wr_o,
	output logic                cart_attached_o
);
	import loader_pkg::*;

	logic              req_wr;
	logic [ADDR_W-1:0] req_addr;
	byte_t             req_data;
	logic              prg_done;
	word16_t           prg_end;
	logic              init_req;
	logic [ADDR_W-1:0] init_addr;
	byte_t             init_data;

	download_parser #(
		.ADDR_W    (ADDR_W),
		.CART_BASE (CART_BASE),
		.TAP_BASE  (TAP_BASE)
	) u_download_parser (
		.clk_sys           (clk_sys),
		.reset_n           (reset_n),
		.ioctl_download_i  (ioctl_download_i),
		.ioctl_index_i     (ioctl_index_i),
		.ioctl_addr_i      (ioctl_addr_i),
		.ioctl_data_i      (ioctl_data_i),
		.ioctl_wr_i        (ioctl_wr_i),
		.req_wr_o          (req_wr),
		.req_addr_o        (req_addr),
		.req_data_o        (req_data),
		.prg_done_o        (prg_done),
		.prg_end_o         (prg_end),
		.cart_id_o         (cart_id_o),
		.cart_exrom_o      (cart_exrom_o),
		.cart_game_o       (cart_game_o),
		.cart_bank_type_o  (cart_bank_type_o),
		.cart_bank_num_o   (cart_bank_num_o),
		.cart_bank_laddr_o (cart_bank_laddr_o),
		.cart_bank_size_o  (cart_bank_size_o),
		.cart_bank_wr_o    (cart_bank_wr_o),
		.cart_attached_o   (cart_attached_o)
	);

	basic_ptr_init #(
		.ADDR_W (ADDR_W)
	) u_basic_ptr_init (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.prg_done_i  (prg_done),
		.prg_end_i   (prg_end),
		.busy_i      (ioctl_wait_o),
		.init_req_o  (init_req),
		.init_addr_o (init_addr),
		.init_data_o (init_data)
	);

	// Pending flag doubles as host wait
	mem_slot_writer #(
		.ADDR_W (ADDR_W)
	) u_mem_slot_writer (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.req_wr_i    (req_wr),
		.req_addr_i  (req_addr),
		.req_data_i  (req_data),
		.init_req_i  (init_req),
		.init_addr_i (init_addr),
		.init_data_i (init_data),
		.io_cycle_i  (io_cycle_i),
		.busy_o      (ioctl_wait_o),
		.mem_ce_o    (mem_ce_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

endmodule

// ==== logic/mem_slot_writer.sv ====
// One write in flight at a time; sources must strobe only while busy_o is low
`timescale 1ns/1ps

module mem_slot_writer #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              req_wr_i,
	input  logic [ADDR_W-1:0] req_addr_i,
	input  loader_pkg::byte_t req_data_i,
	input  logic              init_req_i,
	input  logic [ADDR_W-1:0] init_addr_i,
	input  loader_pkg::byte_t init_data_i,
	input  logic              io_cycle_i,
	output logic              busy_o,
	output logic              mem_ce_o,
	output logic              mem_we_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output loader_pkg::byte_t mem_data_o
);
	import loader_pkg::*;

	logic              pending;
	logic [ADDR_W-1:0] pend_addr;
	byte_t             pend_data;
	logic              io_cycle_d;
	logic              slot_open;   // I/O slot just ended, bus is ours
	logic              slot_close;
	logic              bus_wr;

	assign slot_open  = ~io_cycle_i & io_cycle_d;
	assign slot_close = io_cycle_i & io_cycle_d;

	assign busy_o   = pending;
	assign mem_ce_o = bus_wr;  // Idle slots issue no access
	assign mem_we_o = bus_wr;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			pending    <= 1'b0;
			io_cycle_d <= 1'b0;
			bus_wr     <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;

			// ==============================
			// Memory side
			// ==============================
			if (slot_open && pending) begin
				bus_wr     <= 1'b1;
				mem_addr_o <= pend_addr;
				mem_data_o <= pend_data;
				pending    <= 1'b0;  // Frees the register for the next byte
			end else if (slot_close) begin
				bus_wr <= 1'b0;
			end

			// ==============================
			// Request side
			// ==============================
			if (req_wr_i) begin
				pend_addr <= req_addr_i;
				pend_data <= req_data_i;
				pending   <= 1'b1;
			end else if (init_req_i) begin
				pend_addr <= init_addr_i;
				pend_data <= init_data_i;
				pending   <= 1'b1;
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the loader testbench with Verilator, runs it and checks the result line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_loader -o tb_loader_sim

output="$(./obj_dir/tb_loader_sim)"
echo "${output}"

if grep -qF "Simulation finished: PASS" <<< "${output}"; then
	exit 0
fi
exit 1

// ==== sim/tb_loader.sv ====
// Default 25-bit map with CART_BASE 100000 and TAP_BASE 200000; slots come from this testbench only
`timescale 1ns/1ps

module tb_loader;
	import loader_pkg::*;

	localparam int                ADDR_W     = 25;
	localparam logic [ADDR_W-1:0] CART_BASE  = 25'h100000;
	localparam logic [ADDR_W-1:0] TAP_BASE   = 25'h200000;
	localparam int                CLK_PERIOD = 20;
	localparam int                SLOT_MAX   = 40;   // Longest sparse slot period in cycles
	localparam int                ZP_WALK    = 256;  // Zero-page scan takes one address per cycle
	localparam logic [31:0]       LFSR_SEED  = 32'h2e66_daca;
	localparam logic [31:0]       LFSR_TAPS  = 32'h8020_0003;

	logic              clk_sys;
	logic              reset_n;
	logic              ioctl_download_i;
	logic [7:0]        ioctl_index_i;
	logic [ADDR_W-1:0] ioctl_addr_i;
	byte_t             ioctl_data_i;
	logic              ioctl_wr_i;
	logic              ioctl_wait_o;
	logic              io_cycle_i;
	logic              mem_ce_o;
	logic              mem_we_o;
	logic [ADDR_W-1:0] mem_addr_o;
	byte_t             mem_data_o;
	word16_t           cart_id_o;
	byte_t             cart_exrom_o;
	byte_t             cart_game_o;
	byte_t             cart_bank_type_o;
	word16_t           cart_bank_num_o;
	word16_t           cart_bank_laddr_o;
	word16_t           cart_bank_size_o;
	logic              cart_bank_wr_o;
	logic              cart_attached_o;

	logic [31:0] stim_state;
	logic [31:0] slot_state;
	logic        sparse_slots;
	logic        lengths_ready;
	int          total_len;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          wait_cycles;      // Host cycles stalled on ioctl_wait_o

	logic [31:0] wr_addr_q[$];     // Memory model keeps writes in arrival order
	byte_t       wr_data_q[$];
	logic [31:0] exp_addr_q[$];
	byte_t       exp_data_q[$];
	logic [55:0] bank_q[$];        // {type, num, laddr, size} per bank strobe

	loader_top #(
		.ADDR_W    (ADDR_W),
		.CART_BASE (CART_BASE),
		.TAP_BASE  (TAP_BASE)
	) u_loader_top (
		.clk_sys           (clk_sys),
		.reset_n           (reset_n),
		.ioctl_download_i  (ioctl_download_i),
		.ioctl_index_i     (ioctl_index_i),
		.ioctl_addr_i      (ioctl_addr_i),
		.ioctl_data_i      (ioctl_data_i),
		.ioctl_wr_i        (ioctl_wr_i),
		.ioctl_wait_o      (ioctl_wait_o),
		.io_cycle_i        (io_cycle_i),
		.mem_ce_o          (mem_ce_o),
		.mem_we_o          (mem_we_o),
		.mem_addr_o        (mem_addr_o),
		.mem_data_o        (mem_data_o),
		.cart_id_o         (cart_id_o),
		.cart_exrom_o      (cart_exrom_o),
		.cart_game_o       (cart_game_o),
		.cart_bank_type_o  (cart_bank_type_o),
		.cart_bank_num_o   (cart_bank_num_o),
		.cart_bank_laddr_o (cart_bank_laddr_o),
		.cart_bank_size_o  (cart_bank_size_o),
		.cart_bank_wr_o    (cart_bank_wr_o),
		.cart_attached_o   (cart_attached_o)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ==============================
	// Helpers
	// ==============================

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int nbits);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val   = {val[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
		end
		return val;
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic send_byte(input int addr, input byte_t data);
		while (ioctl_wait_o) begin
			wait_cycles++;
			next_cycle();
		end
		ioctl_addr_i = ADDR_W'(addr);
		ioctl_data_i = data;
		ioctl_wr_i   = 1'b1;
		next_cycle();
		ioctl_wr_i = 1'b0;
		next_cycle();  // Wait rises two edges after the strobe
	endtask

	task automatic start_download(input byte_t idx);
		ioctl_index_i    = idx;
		ioctl_download_i = 1'b1;
		next_cycle();
	endtask

	task automatic stop_download();
		ioctl_download_i = 1'b0;
		next_cycle();
	endtask

	task automatic expect_write(input logic [31:0] addr, input byte_t data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic clear_logs();
		wr_addr_q.delete();
		wr_data_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
		bank_q.delete();
	endtask

	task automatic wait_for_writes(input int count);
		int limit;
		int cycles;
		limit  = (count + 1) * SLOT_MAX * 4 + ZP_WALK;
		cycles = 0;
		while (wr_addr_q.size() < count && cycles < limit) begin
			next_cycle();
			cycles++;
		end
		if (wr_addr_q.size() < count) begin
			$display("Timed out waiting for %0d memory writes, %0d seen", count, wr_addr_q.size());
			errors++;
		end
	endtask

	task automatic check_writes();
		int n;
		if (wr_addr_q.size() != exp_addr_q.size()) begin
			$display("Expected %0d memory writes but saw %0d", exp_addr_q.size(), wr_addr_q.size());
			errors++;
		end
		n = (wr_addr_q.size() < exp_addr_q.size()) ? wr_addr_q.size() : exp_addr_q.size();
		for (int i = 0; i < n; i++) begin
			if (wr_addr_q[i] != exp_addr_q[i]) report_mismatch("mem_addr_o", wr_addr_q[i],
					exp_addr_q[i]);
			if (wr_data_q[i] != exp_data_q[i]) report_mismatch("mem_data_o", 32'(wr_data_q[i]),
					32'(exp_data_q[i]));
		end
	endtask

	task automatic load_tap(input int len);
		byte_t d;
		start_download(IDX_TAP);
		for (int i = 0; i < len; i++) begin
			d = byte_t'(lfsr_take(stim_state, 8));
			send_byte(i, d);
			expect_write(32'(TAP_BASE) + 32'(i), d);
		end
		stop_download();
	endtask

	task automatic close_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("[TEST] %s: ok", name);
		end else begin
			tests_failed++;
			$display("[TEST] %s: FAILED with %0d errors", name, errors - err_start);
		end
	endtask

	// ==============================
	// Slot driver and monitors
	// ==============================

	initial begin : slot_driver
		int hi_len;
		int lo_len;
		io_cycle_i = 1'b1;
		next_cycle();
		forever begin
			if (sparse_slots)
				hi_len = 2 + int'(lfsr_take(slot_state, 5));  // Long core ownership
			else
				hi_len = 2 + int'(lfsr_take(slot_state, 8) % 32'd3);
			lo_len     = 1 + int'(lfsr_take(slot_state, 8) % 32'd6);
			io_cycle_i = 1'b1;
			repeat (hi_len) next_cycle();
			io_cycle_i = 1'b0;
			repeat (lo_len) next_cycle();
		end
	end

	// A write is complete when the chip enable drops
	always @(negedge mem_ce_o) begin
		if (reset_n === 1'b1) begin
			wr_addr_q.push_back(32'(mem_addr_o));
			wr_data_q.push_back(mem_data_o);
		end
	end

	always @(posedge mem_we_o) begin
		if (io_cycle_i) begin
			$display("mem_we_o rose while io_cycle_i was high at %0t", $time);
			errors++;
		end
	end

	// No reads exist here, so every enabled cycle must be a write
	always @(negedge clk_sys) begin
		if (reset_n === 1'b1) begin
			if (mem_ce_o === 1'b1 && mem_we_o !== 1'b1)
				report_mismatch("mem_we_o", 32'(mem_we_o), 32'h1);
			if (mem_ce_o === 1'b0 && mem_we_o !== 1'b0)
				report_mismatch("mem_we_o", 32'(mem_we_o), 32'h0);
		end
	end

	always @(negedge clk_sys) begin
		if (cart_bank_wr_o === 1'b1) begin
			bank_q.push_back({cart_bank_type_o, cart_bank_num_o, cart_bank_laddr_o,
				cart_bank_size_o});
		end
	end

	initial begin : watchdog
		longint limit_ns;
		wait (lengths_ready === 1'b1);
		limit_ns = longint'(total_len) * 40 * SLOT_MAX * CLK_PERIOD;
		#(limit_ns);
		$display("Watchdog expired after %0d ns, a test did not finish", limit_ns);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin : main
		int          prg_len;
		int          crt_len[2];
		int          tap_len;
		int          bp_len;
		int          err_start;
		int          pos;
		int          base;
		logic [15:0] prg_start;
		logic [15:0] prg_end;
		word16_t     id;
		byte_t       exrom;
		byte_t       game;
		byte_t       d;
		byte_t       hdr[16];
		logic [55:0] bank_exp[2];

		clk_sys          = 1'b0;
		reset_n          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = 8'h00;
		ioctl_addr_i     = '0;
		ioctl_data_i     = 8'h00;
		ioctl_wr_i       = 1'b0;
		sparse_slots     = 1'b0;
		lengths_ready    = 1'b0;
		stim_state       = LFSR_SEED;
		slot_state       = LFSR_SEED;
		errors           = 0;
		tests_run        = 0;
		tests_failed     = 0;
		wait_cycles      = 0;

		// All lengths up front so the watchdog knows the budget
		prg_len    = 1 + int'(lfsr_take(stim_state, 8) % 32'd40);
		prg_start  = 16'h0800 + 16'(lfsr_take(stim_state, 16) % 32'hE000);
		crt_len[0] = 1 + int'(lfsr_take(stim_state, 8) % 32'd32);
		crt_len[1] = 1 + int'(lfsr_take(stim_state, 8) % 32'd32);
		tap_len    = 1 + int'(lfsr_take(stim_state, 8) % 32'd40);
		bp_len     = 64 + int'(lfsr_take(stim_state, 6));
		total_len  = prg_len + 14 + ZP_WALK + 96 + crt_len[0] + crt_len[1] + tap_len + bp_len;
		lengths_ready = 1'b1;

		repeat (16) @(posedge clk_sys);
		#1;
		reset_n = 1'b1;

		err_start = errors;
		next_cycle();
		if (mem_ce_o !== 1'b0) report_mismatch("mem_ce_o", 32'(mem_ce_o), 32'h0);
		if (mem_we_o !== 1'b0) report_mismatch("mem_we_o", 32'(mem_we_o), 32'h0);
		if (ioctl_wait_o !== 1'b0) report_mismatch("ioctl_wait_o", 32'(ioctl_wait_o), 32'h0);
		if (cart_bank_wr_o !== 1'b0) report_mismatch("cart_bank_wr_o", 32'(cart_bank_wr_o), 32'h0);
		if (cart_attached_o !== 1'b0) report_mismatch("cart_attached_o", 32'(cart_attached_o),
				32'h0);
		close_test("reset state", err_start);

		// PRG with load address header
		clear_logs();
		err_start = errors;
		start_download(IDX_PRG);
		send_byte(0, prg_start[7:0]);
		send_byte(1, prg_start[15:8]);
		for (int i = 0; i < prg_len; i++) begin
			d = byte_t'(lfsr_take(stim_state, 8));
			send_byte(i + 2, d);
			expect_write(32'(prg_start) + 32'(i), d);
		end
		stop_download();
		prg_end = prg_start + 16'(prg_len);
		expect_write(32'h2B, 8'h01);  // BASIC start $0801
		expect_write(32'h2C, 8'h08);
		for (int k = 0; k < 3; k++) begin
			expect_write(32'h2D + 32'(2 * k), prg_end[7:0]);
			expect_write(32'h2E + 32'(2 * k), prg_end[15:8]);
		end
		expect_write(32'hAC, 8'h00);
		expect_write(32'hAD, 8'h00);
		expect_write(32'hAE, prg_end[7:0]);
		expect_write(32'hAF, prg_end[15:8]);
		wait_for_writes(exp_addr_q.size());
		repeat (ZP_WALK) next_cycle();  // Stray writes would land while the scan runs out
		check_writes();
		close_test("PRG load", err_start);

		// CRT with two CHIP packets
		clear_logs();
		err_start = errors;
		id    = word16_t'(lfsr_take(stim_state, 16));
		exrom = byte_t'(lfsr_take(stim_state, 1));
		game  = byte_t'(lfsr_take(stim_state, 1));
		start_download(IDX_CRT);
		for (int a = 0; a < int'(CRT_CHIP_START); a++) begin
			if (a == int'(CRT_HDR_ID))
				d = id[15:8];
			else if (a == int'(CRT_HDR_ID) + 1)
				d = id[7:0];
			else if (a == int'(CRT_HDR_EXROM))
				d = exrom;
			else if (a == int'(CRT_HDR_GAME))
				d = game;
			else
				d = byte_t'(lfsr_take(stim_state, 8));
			send_byte(a, d);
		end
		pos  = int'(CRT_CHIP_START);
		base = int'(CART_BASE);
		for (int p = 0; p < 2; p++) begin
			bank_exp[p] = {24'(lfsr_take(stim_state, 24)), lfsr_take(stim_state, 32)};
			hdr = '{8'h43, 8'h48, 8'h49, 8'h50, 8'h00, 8'h00, 8'h00, 8'(16 + crt_len[p]),
				8'h00, bank_exp[p][55:48], bank_exp[p][47:40], bank_exp[p][39:32],
				bank_exp[p][31:24], bank_exp[p][23:16], bank_exp[p][15:8], bank_exp[p][7:0]};
			for (int j = 0; j < 16; j++) begin
				send_byte(pos, hdr[j]);
				pos++;
			end
			for (int j = 0; j < crt_len[p]; j++) begin
				d = byte_t'(lfsr_take(stim_state, 8));
				send_byte(pos, d);
				pos++;
				expect_write(32'(base + j), d);
			end
			base = (base + crt_len[p] + 32'h1FFF) & ~32'h1FFF;  // Next 8 KB boundary
		end
		stop_download();
		if (cart_attached_o !== 1'b1) report_mismatch("cart_attached_o", 32'(cart_attached_o),
				32'h1);
		if (cart_id_o !== id) report_mismatch("cart_id_o", 32'(cart_id_o), 32'(id));
		if (cart_exrom_o !== exrom) report_mismatch("cart_exrom_o", 32'(cart_exrom_o), 32'(exrom));
		if (cart_game_o !== game) report_mismatch("cart_game_o", 32'(cart_game_o), 32'(game));
		if (bank_q.size() != 2) begin
			$display("Expected 2 cart_bank_wr_o pulses but saw %0d", bank_q.size());
			errors++;
		end
		for (int p = 0; p < 2 && p < bank_q.size(); p++) begin
			if (bank_q[p][55:48] != bank_exp[p][55:48]) report_mismatch("cart_bank_type_o",
					32'(bank_q[p][55:48]), 32'(bank_exp[p][55:48]));
			if (bank_q[p][47:32] != bank_exp[p][47:32]) report_mismatch("cart_bank_num_o",
					32'(bank_q[p][47:32]), 32'(bank_exp[p][47:32]));
			if (bank_q[p][31:16] != bank_exp[p][31:16]) report_mismatch("cart_bank_laddr_o",
					32'(bank_q[p][31:16]), 32'(bank_exp[p][31:16]));
			if (bank_q[p][15:0] != bank_exp[p][15:0]) report_mismatch("cart_bank_size_o",
					32'(bank_q[p][15:0]), 32'(bank_exp[p][15:0]));
		end
		wait_for_writes(exp_addr_q.size());
		check_writes();
		close_test("CRT load", err_start);

		clear_logs();
		err_start = errors;
		load_tap(tap_len);
		wait_for_writes(exp_addr_q.size());
		check_writes();
		close_test("TAP load", err_start);

		// Long tape with the core holding the bus most of the time
		clear_logs();
		err_start    = errors;
		sparse_slots = 1'b1;
		wait_cycles  = 0;
		load_tap(bp_len);
		wait_for_writes(exp_addr_q.size());
		check_writes();
		if (wait_cycles == 0) begin
			$display("Host was never held off by ioctl_wait_o during the long load");
			errors++;
		end
		sparse_slots = 1'b0;
		close_test("back-pressure", err_start);

		$display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/loader_pkg.sv
logic/download_parser.sv
logic/basic_ptr_init.sv
logic/mem_slot_writer.sv
logic/loader_top.sv
sim/tb_loader.sv
